// ==== design/osd_params.svh ====
/*
 * OSD and video configuration constants
 * register map, RAM depth and reset values of the register file
 */
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

// register map, byte addresses on the register bus
`define OSD_ADDR_OFFSET     8'h80
`define OSD_ADDR_ENABLE     8'h81
`define OSD_ADDR_HIGHLIGHT  8'h82
`define OSD_ADDR_RECONF     8'h83
`define OSD_ADDR_PAD_HI     8'h85
`define OSD_ADDR_PAD_LO     8'h86
`define OSD_ADDR_SCAN_HI    8'h88
`define OSD_ADDR_SCAN_LO    8'h89
`define OSD_ADDR_TIMING0    8'hB3
`define OSD_ADDR_TIMING1    8'hB4
`define OSD_ADDR_TIMING2    8'hB5
`define OSD_ADDR_RESET_DC   8'hF0
`define OSD_ADDR_RESET_CONF 8'hF2

// character RAM size in bytes
`define OSD_CHAR_DEPTH      1024

// reset values
`define OSD_HIGHLIGHT_RST   8'hFF
`define OSD_INTENSITY_RST   9'h100

`endif

// ==== design/osd_pkg.sv ====
/*
 * OSD video package
 * vector types shared by the register file, RAM, shader and top
 */
package osd_pkg;

    // register bus
    typedef logic [7:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;

    // character RAM address, 3-bit page offset then 7-bit low address
    typedef logic [9:0]  char_addr_t;

    // output mode code handed to the HDMI timing side
    typedef logic [3:0]  video_mode_t;

    // scanline darkness, 256 is fully dark
    typedef logic [8:0]  intensity_t;

    // pixel, red in bits 23:16, then green, then blue
    typedef logic [23:0] rgb_t;

    // video line counter
    typedef logic [10:0] line_t;

    // controller word, bit 0 flags a valid packet
    typedef logic [15:0] pad_t;

    // measured timing info, read back as three bytes
    typedef logic [23:0] timing_t;

endpackage

// ==== design/scanline_if.sv ====
/*
 * Scanline settings bus
 * carries the darkening setup from the register file to the shader
 */
`timescale 1ns/1ps

interface scanline_if;
    import osd_pkg::*;

    // darkness of the selected lines
    intensity_t intensity;
    // 0 picks single lines, 1 picks line pairs
    logic       thickness;
    // which parity gets darkened
    logic       oddeven;
    // shading on
    logic       active;

    modport cfg   (output intensity, thickness, oddeven, active);
    modport shade (input  intensity, thickness, oddeven, active);

endinterface

// ==== design/osd_register_file.sv ====
/*
 * OSD register file
 * decodes the byte-wide register bus, holds OSD, video mode and scanline
 * config, muxes status words onto the read data and drives the RAM write port
 */
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_register_file (
    input  logic                clk,
    input  logic                rst_n,
    // register bus from the serial slave
    input  osd_pkg::reg_addr_t  reg_addr,
    input  osd_pkg::reg_data_t  reg_wdata,
    input  logic                reg_write,
    output osd_pkg::reg_data_t  reg_rdata,
    // status from outside
    input  osd_pkg::pad_t       pad_data,
    input  osd_pkg::timing_t    timing_info,
    // character RAM write port
    output osd_pkg::char_addr_t ram_waddr,
    output osd_pkg::reg_data_t  ram_wdata,
    output logic                ram_wren,
    // configuration outputs
    output logic                osd_enable,
    output osd_pkg::reg_data_t  highlight_line,
    output osd_pkg::video_mode_t video_mode,
    output osd_pkg::reg_data_t  reset_conf,
    output logic                reset_dc,
    scanline_if.cfg             scan
);
    import osd_pkg::*;

    // page select for character writes
    logic [2:0] offset_q;
    // raw reconf byte, kept for readback
    reg_data_t  reconf_q;
    // scanline fields
    intensity_t intensity_q;
    logic       thickness_q;
    logic       oddeven_q;
    logic       active_q;
    // next read byte
    reg_data_t  rdata_next;
    // writes below 80 land in the character RAM
    logic       ram_hit;

    assign ram_hit = reg_write && !reg_addr[7];

    ////////////////////
    // read mux
    ////////////////////

    // old register values are returned, a write in the same cycle shows next read
    always_comb begin
        case (reg_addr)
            `OSD_ADDR_OFFSET:     rdata_next = {5'b0, offset_q};
            `OSD_ADDR_ENABLE:     rdata_next = {7'b0, osd_enable};
            `OSD_ADDR_HIGHLIGHT:  rdata_next = highlight_line;
            `OSD_ADDR_RECONF:     rdata_next = reconf_q;
            // controller buttons, high byte then low byte
            `OSD_ADDR_PAD_HI:     rdata_next = pad_data[15:8];
            `OSD_ADDR_PAD_LO:     rdata_next = pad_data[7:0];
            `OSD_ADDR_SCAN_HI:    rdata_next = intensity_q[8:1];
            `OSD_ADDR_SCAN_LO:    rdata_next = {intensity_q[0], thickness_q, oddeven_q,
                                                active_q, 4'b0};
            // timing info, most significant byte first
            `OSD_ADDR_TIMING0:    rdata_next = timing_info[23:16];
            `OSD_ADDR_TIMING1:    rdata_next = timing_info[15:8];
            `OSD_ADDR_TIMING2:    rdata_next = timing_info[7:0];
            `OSD_ADDR_RESET_CONF: rdata_next = reset_conf;
            default:              rdata_next = '0;
        endcase
    end

    // one cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_next;
        end
    end

    ////////////////////
    // config writes
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset_q       <= '0;
            osd_enable     <= 1'b0;
            highlight_line <= `OSD_HIGHLIGHT_RST;
            reconf_q       <= '0;
            video_mode     <= '0;
            intensity_q    <= `OSD_INTENSITY_RST;
            thickness_q    <= 1'b0;
            oddeven_q      <= 1'b0;
            active_q       <= 1'b0;
            reset_conf     <= '0;
        end else if (reg_write) begin
            case (reg_addr)
                `OSD_ADDR_OFFSET:    offset_q       <= reg_wdata[2:0];
                `OSD_ADDR_ENABLE:    osd_enable     <= reg_wdata[0];
                `OSD_ADDR_HIGHLIGHT: highlight_line <= reg_wdata;
                `OSD_ADDR_RECONF: begin
                    reconf_q <= reg_wdata;
                    // 0-3 for 480 sources, 8-B for 240p, others keep the mode
                    case (reg_wdata[3:0])
                        4'h0, 4'h1, 4'h2, 4'h3,
                        4'h8, 4'h9, 4'hA, 4'hB: video_mode <= reg_wdata[3:0];
                        default: ;
                    endcase
                end
                `OSD_ADDR_SCAN_HI:   intensity_q[8:1] <= reg_wdata;
                `OSD_ADDR_SCAN_LO: begin
                    intensity_q[0] <= reg_wdata[7];
                    thickness_q    <= reg_wdata[6];
                    oddeven_q      <= reg_wdata[5];
                    active_q       <= reg_wdata[4];
                end
                `OSD_ADDR_RESET_CONF: reset_conf <= reg_wdata;
                default: ;
            endcase
        end
    end

    ////////////////////
    // pulses and RAM port
    ////////////////////

    // console reset and RAM strobe last one cycle per write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_dc <= 1'b0;
            ram_wren <= 1'b0;
        end else begin
            reset_dc <= reg_write && (reg_addr == `OSD_ADDR_RESET_DC);
            ram_wren <= ram_hit;
        end
    end

    // address placed in the page picked by the offset register
    always_ff @(posedge clk) begin
        if (ram_hit) begin
            ram_waddr <= {offset_q, reg_addr[6:0]};
            ram_wdata <= reg_wdata;
        end
    end

    assign scan.intensity = intensity_q;
    assign scan.thickness = thickness_q;
    assign scan.oddeven   = oddeven_q;
    assign scan.active    = active_q;

endmodule

// ==== design/osd_char_ram.sv ====
/*
 * OSD character RAM
 * simple dual-port byte memory, registered read for the text renderer
 */
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_char_ram (
    input  logic                clk,
    // write side, from the register file
    input  osd_pkg::char_addr_t waddr,
    input  osd_pkg::reg_data_t  wdata,
    input  logic                wren,
    // read side, for the renderer
    input  osd_pkg::char_addr_t raddr,
    output osd_pkg::reg_data_t  rdata
);
    import osd_pkg::*;

    // character storage, contents undefined after power up
    reg_data_t mem [`OSD_CHAR_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== design/scanline_shader.sv ====
/*
 * Scanline shader
 * darkens RGB pixels of selected lines, one registered stage
 */
`timescale 1ns/1ps

module scanline_shader (
    input  logic            clk,
    input  logic            rst_n,
    scanline_if.shade       scan,
    // pixel stream in
    input  osd_pkg::rgb_t   pixel_in,
    input  osd_pkg::line_t  line,
    input  logic            pixel_valid,
    // pixel stream out, one cycle later
    output osd_pkg::rgb_t   pixel_out,
    output logic            pixel_out_valid
);
    import osd_pkg::*;

    // line picked for darkening
    logic       line_sel;
    // bit compared against the parity setting
    logic       line_bit;
    // multiplier, 256 minus intensity
    logic [8:0] scale;
    rgb_t       shaded;

    // one channel times scale, back down to 8 bits
    function automatic logic [7:0] scale_channel(input logic [7:0] ch,
                                                 input logic [8:0] k);
        logic [16:0] prod;
        prod = ch * k;
        return prod[15:8];
    endfunction

    // single lines use bit 0, pairs use bit 1
    assign line_bit = scan.thickness ? line[1] : line[0];
    assign line_sel = scan.active && (line_bit == scan.oddeven);

    // anything past 256 is treated as fully dark
    assign scale = (scan.intensity >= 9'd256) ? 9'd0 : 9'd256 - scan.intensity;

    always_comb begin
        if (line_sel) begin
            shaded[23:16] = scale_channel(pixel_in[23:16], scale);
            shaded[15:8]  = scale_channel(pixel_in[15:8], scale);
            shaded[7:0]   = scale_channel(pixel_in[7:0], scale);
        end else begin
            shaded = pixel_in;
        end
    end

    ////////////////////
    // output stage
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_out_valid <= 1'b0;
        end else begin
            pixel_out_valid <= pixel_valid;
        end
    end

    // new pixel every cycle, no stall
    always_ff @(posedge clk) begin
        pixel_out <= shaded;
    end

endmodule

// ==== design/osd_video_top.sv ====
/*
 * OSD and video config top
 * register file, character RAM and scanline shader on plain ports
 */
`timescale 1ns/1ps

module osd_video_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // register bus
    input  osd_pkg::reg_addr_t   reg_addr,
    input  osd_pkg::reg_data_t   reg_wdata,
    input  logic                 reg_write,
    output osd_pkg::reg_data_t   reg_rdata,
    // status in
    input  osd_pkg::pad_t        pad_data,
    input  osd_pkg::timing_t     timing_info,
    // renderer read port
    input  osd_pkg::char_addr_t  char_raddr,
    output osd_pkg::reg_data_t   char_rdata,
    // pixel path
    input  osd_pkg::rgb_t        pixel_in,
    input  osd_pkg::line_t       line,
    input  logic                 pixel_valid,
    output osd_pkg::rgb_t        pixel_out,
    output logic                 pixel_out_valid,
    // config out
    output logic                 osd_enable,
    output osd_pkg::reg_data_t   highlight_line,
    output osd_pkg::video_mode_t video_mode,
    output osd_pkg::reg_data_t   reset_conf,
    output logic                 reset_dc
);
    import osd_pkg::*;

    // RAM write port between register file and RAM
    char_addr_t ram_waddr;
    reg_data_t  ram_wdata;
    logic       ram_wren;

    // scanline settings
    scanline_if scan_bus ();

    osd_register_file u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_write      (reg_write),
        .reg_rdata      (reg_rdata),
        .pad_data       (pad_data),
        .timing_info    (timing_info),
        .ram_waddr      (ram_waddr),
        .ram_wdata      (ram_wdata),
        .ram_wren       (ram_wren),
        .osd_enable     (osd_enable),
        .highlight_line (highlight_line),
        .video_mode     (video_mode),
        .reset_conf     (reset_conf),
        .reset_dc       (reset_dc),
        .scan           (scan_bus.cfg)
    );

    osd_char_ram u_char_ram (
        .clk   (clk),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .wren  (ram_wren),
        .raddr (char_raddr),
        .rdata (char_rdata)
    );

    scanline_shader u_shader (
        .clk             (clk),
        .rst_n           (rst_n),
        .scan            (scan_bus.shade),
        .pixel_in        (pixel_in),
        .line            (line),
        .pixel_valid     (pixel_valid),
        .pixel_out       (pixel_out),
        .pixel_out_valid (pixel_out_valid)
    );

endmodule

// ==== verification/tb_osd_video_top.sv ====
/*
 * OSD video top testbench
 * register map, character RAM, status reads, scanline shading, reset pulse
 */
`timescale 1ns/1ps
`include "osd_params.svh"

module tb_osd_video_top;
    import osd_pkg::*;

    localparam int CLK_PERIOD = 100;
    // the full run takes about 600 cycles
    localparam int WATCHDOG_CYCLES = 3000;

    logic clk = 1'b0;
    logic rst_n;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata, reg_rdata, char_rdata, highlight_line, reset_conf;
    logic reg_write, pixel_valid, pixel_out_valid, osd_enable, reset_dc;
    pad_t pad_data;
    timing_t timing_info;
    char_addr_t char_raddr;
    rgb_t pixel_in, pixel_out;
    line_t line;
    video_mode_t video_mode;

    // register and RAM model
    logic [2:0] m_offset;
    logic m_enable, m_thick, m_oddeven, m_active;
    reg_data_t m_highlight, m_reconf, m_reset_conf;
    video_mode_t m_mode;
    intensity_t m_intensity;
    reg_data_t ram_m [`OSD_CHAR_DEPTH];
    char_addr_t written_q[$];

    logic [31:0] rng_state = 32'h7871e4f0;
    int err_byte = 0, err_mode = 0, err_pixel = 0, err_bit = 0;
    // pixel compare pipeline
    logic shade_on = 1'b0;
    rgb_t pend_pixel;
    logic pend_valid;

    osd_video_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // random numbers and reference model
    ////////////////////

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // mode only moves for 0-3 and 8-B
    function automatic video_mode_t expected_mode(input video_mode_t cur, input reg_data_t rc);
        if (rc[3:0] <= 4'h3 || (rc[3:0] >= 4'h8 && rc[3:0] <= 4'hB))
            return rc[3:0];
        return cur;
    endfunction

    function automatic reg_data_t expected_read(input reg_addr_t a);
        case (a)
            8'h80: return {5'b0, m_offset};
            8'h81: return {7'b0, m_enable};
            8'h82: return m_highlight;
            8'h83: return m_reconf;
            8'h85: return pad_data[15:8];
            8'h86: return pad_data[7:0];
            8'h88: return m_intensity[8:1];
            8'h89: return {m_intensity[0], m_thick, m_oddeven, m_active, 4'b0};
            8'hB3: return timing_info[23:16];
            8'hB4: return timing_info[15:8];
            8'hB5: return timing_info[7:0];
            8'hF2: return m_reset_conf;
            default: return 8'h00;
        endcase
    endfunction

    // each channel times (256 - intensity) shifted down by 8
    function automatic rgb_t expected_pixel(input rgb_t p, input line_t ln);
        int k;
        rgb_t r;
        logic sel;
        sel = m_active && ((m_thick ? ln[1] : ln[0]) == m_oddeven);
        if (!sel)
            return p;
        k = 256 - int'(m_intensity);
        for (int c = 0; c < 3; c++)
            r[c*8 +: 8] = 8'((int'(p[c*8 +: 8]) * k) >> 8);
        return r;
    endfunction

    function automatic void apply_write(input reg_addr_t a, input reg_data_t d);
        if (!a[7])
            ram_m[{m_offset, a[6:0]}] = d;
        case (a)
            8'h80: m_offset = d[2:0];
            8'h81: m_enable = d[0];
            8'h82: m_highlight = d;
            8'h83: begin
                m_reconf = d;
                m_mode = expected_mode(m_mode, d);
            end
            8'h88: m_intensity[8:1] = d;
            8'h89: {m_intensity[0], m_thick, m_oddeven, m_active} = d[7:4];
            8'hF2: m_reset_conf = d;
            default: ;
        endcase
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_byte(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            err_byte++;
            $display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_mode(input video_mode_t got, input video_mode_t exp);
        if (got !== exp) begin
            err_mode++;
            $display("FAIL %0t: video_mode got %0h expected %0h", $time, got, exp);
        end
    endtask

    task automatic check_pixel(input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            err_pixel++;
            $display("FAIL %0t: pixel_out got %06h expected %06h", $time, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_bit++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // bus tasks start and end 1 ns after a rising edge
    ////////////////////

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        reg_addr = a;
        reg_wdata = d;
        reg_write = 1'b1;
        @(posedge clk);
        #1;
        reg_write = 1'b0;
        apply_write(a, d);
    endtask

    task automatic read_check(input reg_addr_t a);
        reg_addr = a;
        @(posedge clk);
        #1;
        check_byte(reg_rdata, expected_read(a), $sformatf("read of %02h", a));
    endtask

    task automatic ram_check(input char_addr_t a);
        char_raddr = a;
        @(posedge clk);
        #1;
        check_byte(char_rdata, ram_m[a], $sformatf("char RAM at %03h", a));
    endtask

    task automatic check_levels();
        check_bit(osd_enable, m_enable, "osd_enable");
        check_byte(highlight_line, m_highlight, "highlight_line");
        check_byte(reset_conf, m_reset_conf, "reset_conf");
        check_mode(video_mode, m_mode);
    endtask

    // output seen mid-cycle belongs to the inputs captured one cycle before
    always @(negedge clk) begin
        if (shade_on) begin
            check_bit(pixel_out_valid, pend_valid, "pixel_out_valid");
            if (pend_valid)
                check_pixel(pixel_out, pend_pixel);
        end
        pend_pixel = expected_pixel(pixel_in, line);
        pend_valid = pixel_valid;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        reg_addr_t a;
        char_addr_t ca;
        rst_n = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        reg_write = 1'b0;
        pad_data = '0;
        timing_info = '0;
        char_raddr = '0;
        pixel_in = '0;
        line = '0;
        pixel_valid = 1'b0;
        {m_offset, m_enable, m_thick, m_oddeven, m_active} = '0;
        {m_reconf, m_reset_conf, m_mode} = '0;
        m_highlight = `OSD_HIGHLIGHT_RST;
        m_intensity = `OSD_INTENSITY_RST;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values
        check_levels();
        check_bit(reset_dc, 1'b0, "reset_dc after reset");
        check_bit(pixel_out_valid, 1'b0, "pixel_out_valid after reset");
        for (int i = 8'h80; i <= 8'h89; i++)
            read_check(reg_addr_t'(i));
        read_check(`OSD_ADDR_RESET_CONF);

        // config writes and readback on mapped and unmapped addresses
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            case (r[11:8] % 12)
                0: a = 8'h80;
                1: a = 8'h81;
                2: a = 8'h82;
                3: a = 8'h88;
                4: a = 8'h89;
                5: a = 8'hF2;
                6: a = 8'h84;
                7: a = 8'h87;
                8: a = 8'h8A;
                9: a = 8'hA0;
                10: a = 8'hC7;
                default: a = 8'hFF;
            endcase
            write_reg(a, r[7:0]);
            check_levels();
            read_check(a);
        end
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            write_reg(`OSD_ADDR_RECONF, r[7:0]);
            check_mode(video_mode, m_mode);
            read_check(`OSD_ADDR_RECONF);
        end

        // character RAM writes at offset page plus 7-bit low address
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            write_reg(`OSD_ADDR_OFFSET, {5'b0, r[2:0]});
            write_reg({1'b0, r[14:8]}, r[23:16]);
            written_q.push_back({r[2:0], r[14:8]});
        end
        // stored two edges after the write edge
        @(posedge clk);
        #1;
        foreach (written_q[i])
            ram_check(written_q[i]);
        // same low address on another page leaves earlier entries intact
        for (int i = 0; i < 8; i++) begin
            ca = written_q[i];
            r = next_rand();
            write_reg(`OSD_ADDR_OFFSET, {5'b0, ca[9:7] ^ 3'd5});
            write_reg({1'b0, ca[6:0]}, r[7:0]);
            written_q.push_back({ca[9:7] ^ 3'd5, ca[6:0]});
        end
        @(posedge clk);
        #1;
        foreach (written_q[i])
            ram_check(written_q[i]);

        // status words from outside
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            pad_data = r[15:0];
            timing_info = timing_t'(next_rand());
            read_check(`OSD_ADDR_PAD_HI);
            read_check(`OSD_ADDR_PAD_LO);
            read_check(`OSD_ADDR_TIMING0);
            read_check(`OSD_ADDR_TIMING1);
            read_check(`OSD_ADDR_TIMING2);
        end

        // first shading rounds hit fully dark and no darkening
        shade_on = 1'b1;
        for (int n = 0; n < 6; n++) begin
            r = next_rand();
            if (n == 0)
                m_intensity = 9'd256;
            else if (n == 1)
                m_intensity = 9'd0;
            else
                m_intensity = 9'(r % 257);
            write_reg(`OSD_ADDR_SCAN_HI, m_intensity[8:1]);
            write_reg(`OSD_ADDR_SCAN_LO, {m_intensity[0], r[29:28], r[27] | (n < 2), 4'h0});
            for (int i = 0; i < 40; i++) begin
                r = next_rand();
                pixel_in = r[23:0];
                line = line_t'(next_rand());
                pixel_valid = (r[27:24] != 4'h0);
                @(posedge clk);
                #1;
            end
            pixel_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        shade_on = 1'b0;

        // console reset pulse shows one cycle after the write edge
        write_reg(`OSD_ADDR_RESET_DC, reg_data_t'(next_rand()));
        check_bit(reset_dc, 1'b1, "reset_dc after F0 write");
        @(posedge clk);
        #1;
        check_bit(reset_dc, 1'b0, "reset_dc one cycle later");
        write_reg(`OSD_ADDR_RESET_CONF, 8'h5A);
        check_bit(reset_dc, 1'b0, "reset_dc after F2 write");
        write_reg(8'hF1, 8'hFF);
        check_bit(reset_dc, 1'b0, "reset_dc after F1 write");
        check_levels();

        @(posedge clk);
        #1;
        $display("errors: byte %0d, mode %0d, pixel %0d, bit %0d",
                 err_byte, err_mode, err_pixel, err_bit);
        if (err_byte + err_mode + err_pixel + err_bit == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/osd_pkg.sv
design/scanline_if.sv
design/osd_register_file.sv
design/osd_char_ram.sv
design/scanline_shader.sv
design/osd_video_top.sv
verification/tb_osd_video_top.sv

// ==== run.sh ====
#!/bin/bash
# builds the OSD video testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_osd_video_top \
    -o tb_osd_video_top > build.log 2>&1 \
    && ./obj_dir/tb_osd_video_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation reported errors"; exit 1; }
exit 0
